// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
TOP        := abc_trace_tb
FILELIST   := build.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
+incdir+include
src/abc_isa_pkg.sv
src/trace_rec_pkg.sv
src/insn_decoder.sv
src/trace_capture.sv
src/trace_ctrl.sv
src/drop_counter.sv
src/trace_fifo.sv
src/abc_trace_top.sv
verif/abc_trace_tb.sv

// File: include/abc_trace_defs.svh
`ifndef ABC_TRACE_DEFS_SVH
`define ABC_TRACE_DEFS_SVH

// Observed core widths
`define ABC_DWIDTH 8
`define ABC_AWIDTH 8
`define ABC_ICWIDTH 8
`define ABC_SPWIDTH 8

// Record FIFO
`define TRACE_FIFO_DEPTH 8
`define TRACE_FIFO_AW 3

// Drop count saturates here
`define DROP_MAX 255

`endif

// File: src/abc_isa_pkg.sv
`default_nettype none

`include "abc_trace_defs.svh"

package abc_isa_pkg;

    // Top level instruction classes, sub-command meaning depends on class
    typedef enum logic [2:0] {
        CLS_ALU  = 3'd0,
        CLS_TEST = 3'd1,
        CLS_APB  = 3'd2,
        CLS_MISC = 3'd3,
        CLS_JUMP = 3'd4,
        CLS_CALL = 3'd5,
        CLS_RET  = 3'd6,
        CLS_NOP  = 3'd7
    } insn_class_e;

    // When the operand of an instruction becomes visible
    typedef enum logic [1:0] {
        PH_EXEC,
        PH_APBRD,
        PH_MEMRD
    } phase_e;

    typedef struct packed {
        logic [`ABC_ICWIDTH-1:0] pc;
        insn_class_e             cls;
        logic [2:0]              scmd;
        logic                    muxc;
        logic [`ABC_AWIDTH-1:0]  addr;
        logic [`ABC_DWIDTH-1:0]  data;
        logic [`ABC_DWIDTH-1:0]  ramdout;
        logic [`ABC_DWIDTH-1:0]  prdata;
        logic [`ABC_DWIDTH-1:0]  acc_new;
        logic [`ABC_SPWIDTH-1:0] sp;
        logic                    flags;
        logic                    isr;
        logic                    debug1;
        logic                    debug2;
    } probe_s;

endpackage

`default_nettype wire

// File: src/abc_trace_top.sv
`default_nettype none

`include "abc_trace_defs.svh"

module abc_trace_top
    import abc_isa_pkg::*;
    import trace_rec_pkg::*;
(
    input  wire         PCLKD,
    input  wire         rst,
    input  wire         trace_en,
    input  wire probe_s probe,
    input  wire         trace_ready,
    output logic        trace_valid,
    output trace_rec_s  trace
);

    trace_rec_s             cand;
    logic                   cand_valid;
    logic                   push;
    trace_rec_s             push_rec;
    logic                   full;
    logic                   inc;
    logic                   clr;
    logic [`ABC_DWIDTH-1:0] count;

    trace_capture capture_i (
        .PCLKD      (PCLKD),
        .rst        (rst),
        .probe      (probe),
        .cand       (cand),
        .cand_valid (cand_valid)
    );

    trace_ctrl ctrl_i (
        .PCLKD      (PCLKD),
        .rst        (rst),
        .trace_en   (trace_en),
        .cand       (cand),
        .cand_valid (cand_valid),
        .full       (full),
        .count      (count),
        .push       (push),
        .push_rec   (push_rec),
        .inc        (inc),
        .clr        (clr)
    );

    drop_counter drop_i (
        .PCLKD (PCLKD),
        .rst   (rst),
        .inc   (inc),
        .clr   (clr),
        .count (count)
    );

    trace_fifo fifo_i (
        .PCLKD       (PCLKD),
        .rst         (rst),
        .push        (push),
        .push_rec    (push_rec),
        .full        (full),
        .trace_ready (trace_ready),
        .trace_valid (trace_valid),
        .trace       (trace)
    );

endmodule

`default_nettype wire

// File: src/drop_counter.sv
`default_nettype none

`include "abc_trace_defs.svh"

module drop_counter (
    input  wire                     PCLKD,
    input  wire                     rst,
    input  wire                     inc,
    input  wire                     clr,
    output logic [`ABC_DWIDTH-1:0]  count
);

    localparam logic [`ABC_DWIDTH-1:0] SAT = `DROP_MAX;

    always_ff @(posedge PCLKD)
    begin
        if (rst || clr)
        begin
            count <= '0;
        end
        else if (inc && count != SAT)
        begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/insn_decoder.sv
`default_nettype none

`include "abc_trace_defs.svh"

module insn_decoder
    import abc_isa_pkg::*;
(
    input  wire probe_s              probe,
    output phase_e                   phase,
    output logic [`ABC_DWIDTH-1:0]   operand
);

    always_comb
    begin
        phase = PH_EXEC;
        case (probe.cls)
            CLS_ALU, CLS_TEST:
            begin
                // Slot bit 0 selects a memory operand
                if (probe.muxc)
                begin
                    phase = PH_MEMRD;
                end
            end
            CLS_APB:
            begin
                // APBREAD and APBREADZ
                if (probe.scmd == 3'd3 || probe.scmd == 3'd7)
                begin
                    phase = PH_APBRD;
                end
            end
            CLS_MISC:
            begin
                // RAMREAD and POP
                if (probe.scmd == 3'd3 || probe.scmd == 3'd5)
                begin
                    phase = PH_MEMRD;
                end
            end
            default:
            begin
                phase = PH_EXEC;
            end
        endcase
    end

    always_comb
    begin
        case (phase)
            PH_APBRD:
            begin
                operand = probe.prdata;
            end
            PH_MEMRD:
            begin
                // MISC reads land in the accumulator
                operand = (probe.cls == CLS_MISC) ? probe.acc_new : probe.ramdout;
            end
            default:
            begin
                operand = probe.data;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/trace_capture.sv
`default_nettype none

`include "abc_trace_defs.svh"

module trace_capture
    import abc_isa_pkg::*;
    import trace_rec_pkg::*;
(
    input  wire         PCLKD,
    input  wire         rst,
    input  wire probe_s probe,
    output trace_rec_s  cand,
    output logic        cand_valid
);

    phase_e                 phase;
    logic [`ABC_DWIDTH-1:0] operand;
    logic                   dbg1_q;
    logic                   isr_q;
    logic                   traced;
    isr_edge_e              isr_edge;
    trace_rec_s             rec;

    insn_decoder decoder_i (
        .probe   (probe),
        .phase   (phase),
        .operand (operand)
    );

    // Memory reads complete one cycle after the debug1 strobe
    assign traced = (phase == PH_EXEC  && probe.debug1) ||
                    (phase == PH_MEMRD && dbg1_q) ||
                    (phase == PH_APBRD && probe.debug2);

    always_comb
    begin
        if (probe.isr && !isr_q)
        begin
            isr_edge = EDGE_ENTER;
        end
        else if (!probe.isr && isr_q)
        begin
            isr_edge = EDGE_EXIT;
        end
        else
        begin
            isr_edge = EDGE_NONE;
        end
    end

    always_comb
    begin
        rec = '0;
        rec.isr_edge = isr_edge;
        rec.pc = probe.pc;
        rec.sp = probe.sp;
        if (traced)
        begin
            rec.kind = REC_INSN;
            rec.cls = probe.cls;
            rec.scmd = probe.scmd;
            rec.muxc = probe.muxc;
            rec.operand = operand;
            rec.result = probe.acc_new;
            rec.taken = (probe.cls inside {CLS_JUMP, CLS_CALL, CLS_RET}) && probe.flags;
        end
        else
        begin
            // Bare interrupt edge
            rec.kind = REC_ISR;
        end
    end

    always_ff @(posedge PCLKD)
    begin
        if (rst)
        begin
            dbg1_q <= 1'b0;
            isr_q <= 1'b0;
            cand_valid <= 1'b0;
        end
        else
        begin
            dbg1_q <= probe.debug1;
            isr_q <= probe.isr;
            cand_valid <= traced || (isr_edge != EDGE_NONE);
        end
    end

    always_ff @(posedge PCLKD)
    begin
        cand <= rec;
    end

    // Class seen by the decoder is always a known value out of reset
    cls_known_a: assert property (@(posedge PCLKD) disable iff (rst)
        !$isunknown(probe.cls));

endmodule

`default_nettype wire

// File: src/trace_ctrl.sv
`default_nettype none

`include "abc_trace_defs.svh"

module trace_ctrl
    import trace_rec_pkg::*;
(
    input  wire                     PCLKD,
    input  wire                     rst,
    input  wire                     trace_en,
    input  wire trace_rec_s         cand,
    input  wire                     cand_valid,
    input  wire                     full,
    input  wire [`ABC_DWIDTH-1:0]   count,
    output logic                    push,
    output trace_rec_s              push_rec,
    output logic                    inc,
    output logic                    clr
);

    localparam logic [`ABC_DWIDTH:0] SAT = `DROP_MAX;

    ctrl_state_e            state;
    ctrl_state_e            state_nx;
    logic [`ABC_DWIDTH:0]   mark_sum;
    trace_rec_s             mark_rec;

    // Marker also accounts for a candidate arriving in the marker cycle
    assign mark_sum = {1'b0, count} + {{`ABC_DWIDTH{1'b0}}, cand_valid};

    always_comb
    begin
        mark_rec = '0;
        mark_rec.kind = REC_OVERFLOW;
        mark_rec.operand = (mark_sum > SAT) ? SAT[`ABC_DWIDTH-1:0] : mark_sum[`ABC_DWIDTH-1:0];
    end

    always_comb
    begin
        state_nx = state;
        push = 1'b0;
        push_rec = cand;
        inc = 1'b0;
        clr = 1'b0;
        case (state)
            ST_OFF:
            begin
                // Pending drops are discarded
                clr = 1'b1;
                if (trace_en)
                begin
                    state_nx = ST_RUN;
                end
            end
            ST_RUN:
            begin
                if (!trace_en)
                begin
                    state_nx = ST_OFF;
                end
                else if (cand_valid && full)
                begin
                    inc = 1'b1;
                    state_nx = ST_DROP;
                end
                else
                begin
                    push = cand_valid;
                end
            end
            ST_DROP:
            begin
                if (!trace_en)
                begin
                    state_nx = ST_OFF;
                end
                else
                begin
                    inc = cand_valid;
                    if (!full)
                    begin
                        state_nx = ST_MARK;
                    end
                end
            end
            default:
            begin
                if (!trace_en)
                begin
                    state_nx = ST_OFF;
                end
                else
                begin
                    push = 1'b1;
                    push_rec = mark_rec;
                    clr = 1'b1;
                    state_nx = ST_RUN;
                end
            end
        endcase
    end

    always_ff @(posedge PCLKD)
    begin
        if (rst)
        begin
            state <= ST_OFF;
        end
        else
        begin
            state <= state_nx;
        end
    end

    // FIFO never sees a write while it reports full
    push_not_full_a: assert property (@(posedge PCLKD) disable iff (rst)
        push |-> !full);

endmodule

`default_nettype wire

// File: src/trace_fifo.sv
`default_nettype none

`include "abc_trace_defs.svh"

module trace_fifo
    import trace_rec_pkg::*;
(
    input  wire             PCLKD,
    input  wire             rst,
    input  wire             push,
    input  wire trace_rec_s push_rec,
    output logic            full,
    input  wire             trace_ready,
    output logic            trace_valid,
    output trace_rec_s      trace
);

    localparam int DEPTH = `TRACE_FIFO_DEPTH;

    trace_rec_s                 mem [DEPTH];
    logic [`TRACE_FIFO_AW-1:0]  wr_ptr;
    logic [`TRACE_FIFO_AW-1:0]  rd_ptr;
    logic [`TRACE_FIFO_AW:0]    occ;
    logic                       wr_en;
    logic                       rd_en;

    // Full is from registered occupancy, a same cycle pop does not help
    assign full = (occ == DEPTH[`TRACE_FIFO_AW:0]);
    assign trace_valid = (occ != '0);
    assign trace = mem[rd_ptr];

    assign wr_en = push && !full;
    assign rd_en = trace_valid && trace_ready;

    always_ff @(posedge PCLKD)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            occ <= occ + {{`TRACE_FIFO_AW{1'b0}}, wr_en} - {{`TRACE_FIFO_AW{1'b0}}, rd_en};
        end
    end

    always_ff @(posedge PCLKD)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= push_rec;
        end
    end

    trace_hold_a: assert property (@(posedge PCLKD) disable iff (rst)
        trace_valid && !trace_ready |=> trace_valid && $stable(trace));

endmodule

`default_nettype wire

// File: src/trace_rec_pkg.sv
`default_nettype none

`include "abc_trace_defs.svh"

package trace_rec_pkg;
    import abc_isa_pkg::*;

    typedef enum logic [1:0] {REC_INSN, REC_ISR, REC_OVERFLOW} rec_kind_e;

    typedef enum logic [1:0] {EDGE_NONE, EDGE_ENTER, EDGE_EXIT} isr_edge_e;

    // One trace record, operand holds the drop count for overflow markers
    typedef struct packed {
        rec_kind_e               kind;
        isr_edge_e               isr_edge;
        logic [`ABC_ICWIDTH-1:0] pc;
        insn_class_e             cls;
        logic [2:0]              scmd;
        logic                    muxc;
        logic [`ABC_DWIDTH-1:0]  operand;
        logic [`ABC_DWIDTH-1:0]  result;
        logic [`ABC_SPWIDTH-1:0] sp;
        logic                    taken;
    } trace_rec_s;

    typedef enum logic [1:0] {ST_OFF, ST_RUN, ST_DROP, ST_MARK} ctrl_state_e;

endpackage

`default_nettype wire

// File: verif/abc_trace_tb.sv
`default_nettype none

`include "abc_trace_defs.svh"

module abc_trace_tb
    import abc_isa_pkg::*;
    import trace_rec_pkg::*;
();

    localparam int PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int DRAIN_LIMIT = 60;
    localparam int SETTLE_CYCLES = 6;

    logic        PCLKD;
    logic        rst;
    logic        trace_en;
    probe_s      probe;
    logic        trace_ready;
    logic        trace_valid;
    trace_rec_s  trace;

    trace_rec_s  exp_q[$];
    string       test_name;
    int          checks;
    int          errors;

    abc_trace_top abc_trace_i (
        .PCLKD       (PCLKD),
        .rst         (rst),
        .trace_en    (trace_en),
        .probe       (probe),
        .trace_ready (trace_ready),
        .trace_valid (trace_valid),
        .trace       (trace)
    );

    initial
    begin
        PCLKD = 1'b0;
        forever
        begin
            #(PERIOD / 2) PCLKD = ~PCLKD;
        end
    end

    initial
    begin
        #((NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * PERIOD);
        $display("Watchdog expired in test %s, the run did not complete in time", test_name);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [`ABC_DWIDTH-1:0] rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[`ABC_DWIDTH-1:0];
    endfunction

    function automatic probe_s idle_probe();
        probe_s p;
        p = '0;
        p.cls = CLS_NOP;
        return p;
    endfunction

    function automatic probe_s rand_insn(insn_class_e cls, logic [2:0] scmd, logic muxc);
        probe_s                 p;
        logic [`ABC_DWIDTH-1:0] b;
        p = '0;
        p.pc = rand_byte();
        p.cls = cls;
        p.scmd = scmd;
        p.muxc = muxc;
        p.addr = rand_byte();
        p.data = rand_byte();
        p.ramdout = rand_byte();
        p.prdata = rand_byte();
        p.acc_new = rand_byte();
        p.sp = rand_byte();
        b = rand_byte();
        p.flags = b[0];
        return p;
    endfunction

    // Expected record of a traced instruction
    function automatic trace_rec_s insn_rec(probe_s p, logic [`ABC_DWIDTH-1:0] operand,
                                            isr_edge_e e);
        trace_rec_s rec;
        rec = '0;
        rec.kind = REC_INSN;
        rec.isr_edge = e;
        rec.pc = p.pc;
        rec.cls = p.cls;
        rec.scmd = p.scmd;
        rec.muxc = p.muxc;
        rec.operand = operand;
        rec.result = p.acc_new;
        rec.sp = p.sp;
        // Only branches report a taken condition
        if (p.cls == CLS_JUMP || p.cls == CLS_CALL || p.cls == CLS_RET)
        begin
            rec.taken = p.flags;
        end
        return rec;
    endfunction

    function automatic trace_rec_s isr_rec(probe_s p, isr_edge_e e);
        trace_rec_s rec;
        rec = '0;
        rec.kind = REC_ISR;
        rec.isr_edge = e;
        rec.pc = p.pc;
        rec.sp = p.sp;
        return rec;
    endfunction

    function automatic trace_rec_s overflow_rec(logic [`ABC_DWIDTH-1:0] dropped);
        trace_rec_s rec;
        rec = '0;
        rec.kind = REC_OVERFLOW;
        rec.operand = dropped;
        return rec;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual)
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic step(input probe_s p);
        @(negedge PCLKD);
        probe = p;
    endtask

    // Idle until the queue empties and then watch for strays
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT)
        begin
            step(idle_probe());
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("Test %s: %0d expected records never left the DUT", test_name,
                     exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (SETTLE_CYCLES) step(idle_probe());
    endtask

    always @(posedge PCLKD)
    begin
        if (!rst && trace_valid && trace_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Test %s: the DUT sent a record that was not expected: %h",
                         test_name, trace);
                errors++;
            end
            else
            begin
                check(test_name, exp_q.pop_front(), trace);
            end
        end
    end

    task automatic traced_exec(input insn_class_e cls, input logic [2:0] scmd,
                               input logic flags);
        probe_s p;
        p = rand_insn(cls, scmd, 1'b0);
        p.flags = flags;
        p.debug1 = 1'b1;
        step(p);
        exp_q.push_back(insn_rec(p, p.data, EDGE_NONE));
    endtask

    // Strobe in the first cycle and operand in the second
    task automatic mem_read_pair(input insn_class_e cls, input logic [2:0] scmd,
                                 input logic muxc);
        probe_s p;
        p = rand_insn(cls, scmd, muxc);
        p.debug1 = 1'b1;
        step(p);
        p.debug1 = 1'b0;
        p.ramdout = rand_byte();
        p.acc_new = rand_byte();
        step(p);
        exp_q.push_back(insn_rec(p, (cls == CLS_MISC) ? p.acc_new : p.ramdout, EDGE_NONE));
    endtask

    task automatic reset_and_disable();
        probe_s p;
        test_name = "reset_disable";
        check(test_name, 0, trace_valid);
        repeat (20)
        begin
            p = rand_insn(CLS_ALU, 3'd1, 1'b0);
            p.debug1 = 1'b1;
            step(p);
        end
        repeat (SETTLE_CYCLES) step(idle_probe());
        check(test_name, 0, trace_valid);
        step(idle_probe());
        trace_en = 1'b1;
        repeat (3) step(idle_probe());
    endtask

    task automatic exec_insns();
        probe_s p;
        test_name = "exec";
        traced_exec(CLS_ALU, 3'd2, 1'b1);
        traced_exec(CLS_JUMP, 3'd5, 1'b1);
        traced_exec(CLS_JUMP, 3'd5, 1'b0);
        traced_exec(CLS_NOP, 3'd0, 1'b1);
        traced_exec(CLS_CALL, 3'd1, 1'b1);
        // Without a strobe there is no record
        p = rand_insn(CLS_ALU, 3'd4, 1'b0);
        step(p);
        p = rand_insn(CLS_JUMP, 3'd2, 1'b0);
        step(p);
        wait_drain();
    endtask

    task automatic mem_reads();
        test_name = "mem_read";
        mem_read_pair(CLS_ALU, 3'd0, 1'b1);
        mem_read_pair(CLS_MISC, 3'd3, 1'b0);
        mem_read_pair(CLS_TEST, 3'd6, 1'b1);
        wait_drain();
    endtask

    task automatic apb_reads();
        probe_s p;
        test_name = "apb_read";
        p = rand_insn(CLS_APB, 3'd3, 1'b0);
        p.debug2 = 1'b1;
        step(p);
        exp_q.push_back(insn_rec(p, p.prdata, EDGE_NONE));
        p = rand_insn(CLS_APB, 3'd7, 1'b1);
        p.debug2 = 1'b1;
        step(p);
        exp_q.push_back(insn_rec(p, p.prdata, EDGE_NONE));
        // debug1 alone does not trace an APB read
        p = rand_insn(CLS_APB, 3'd3, 1'b0);
        p.debug1 = 1'b1;
        step(p);
        wait_drain();
    endtask

    task automatic isr_edges();
        probe_s p;
        test_name = "isr_edges";
        p = idle_probe();
        p.pc = rand_byte();
        p.sp = rand_byte();
        p.isr = 1'b1;
        step(p);
        exp_q.push_back(isr_rec(p, EDGE_ENTER));
        repeat (3)
        begin
            p = idle_probe();
            p.isr = 1'b1;
            step(p);
        end
        p = rand_insn(CLS_RET, 3'd0, 1'b0);
        p.debug1 = 1'b1;
        step(p);
        exp_q.push_back(insn_rec(p, p.data, EDGE_EXIT));
        wait_drain();
    endtask

    task automatic overflow_marker();
        probe_s p;
        test_name = "overflow";
        step(idle_probe());
        trace_ready = 1'b0;
        for (int i = 0; i < 12; i++)
        begin
            p = rand_insn(CLS_ALU, 3'd2, 1'b0);
            p.debug1 = 1'b1;
            step(p);
            // Eight fit in the FIFO and four are dropped
            if (i < `TRACE_FIFO_DEPTH)
            begin
                exp_q.push_back(insn_rec(p, p.data, EDGE_NONE));
            end
        end
        exp_q.push_back(overflow_rec(8'd4));
        repeat (SETTLE_CYCLES) step(idle_probe());
        check(test_name, 1, trace_valid);
        step(idle_probe());
        trace_ready = 1'b1;
        wait_drain();
        traced_exec(CLS_ALU, 3'd1, 1'b0);
        traced_exec(CLS_JUMP, 3'd3, 1'b1);
        wait_drain();
    endtask

    initial
    begin
        void'($urandom(32'h3a95));
        checks = 0;
        errors = 0;
        test_name = "init";
        rst = 1'b1;
        trace_en = 1'b0;
        trace_ready = 1'b1;
        probe = idle_probe();
        repeat (RESET_CYCLES) @(posedge PCLKD);
        @(negedge PCLKD);
        rst = 1'b0;
        reset_and_disable();
        exec_insns();
        mem_reads();
        apb_reads();
        isr_edges();
        overflow_marker();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
